//--- verilog/alu_misc_pkg.sv
package alu_misc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Basic widths
    ////////////////////////////////////////////////////////////////////////////

    // Data word of the integer datapath
    typedef logic [31:0] word_t;

    // Architectural register number
    typedef logic [4:0] reg_index_t;

    // Shift distance, 0 to 31
    typedef logic [4:0] shift_amount_t;

    ////////////////////////////////////////////////////////////////////////////
    // Operation encodings
    ////////////////////////////////////////////////////////////////////////////

    // ALU operations, add/sub/slt follow the unsigned flag
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_nor = 3'd5,
        alu_slt = 3'd6,
        alu_lui = 3'd7
    } alu_op_e;

    // Shifter operations, none gives a zero result
    typedef enum logic [1:0] {
        shift_sll  = 2'd0,
        shift_srl  = 2'd1,
        shift_sra  = 2'd2,
        shift_none = 2'd3
    } shift_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Issue and result bundles
    ////////////////////////////////////////////////////////////////////////////

    // One decoded integer operation from the issue stage
    typedef struct packed {
        alu_op_e       alu_op;
        logic          unsig;
        shift_op_e     shift_op;
        shift_amount_t shift_amount;
        logic          sel_shift;          // Shifter result instead of ALU
        logic          sel_imm;            // Immediate instead of rb as operand B
        word_t         ra;
        word_t         rb;
        word_t         imm;
        reg_index_t    dest;
        logic          write_reg;
        logic          write_on_overflow;  // Write even on signed overflow
    } issue_op_t;

    // Finished result toward writeback
    typedef struct packed {
        reg_index_t dest;
        logic       write_reg;
        logic       overflow;
        word_t      value;
    } result_t;

    // Latency padding to match the longer units
    localparam int DEFAULT_DELAY_STAGES = 3;

    // Result queue entries, also the issuer's credit count, at least 2
    localparam int DEFAULT_RESULT_DEPTH = 4;

endpackage

//--- verilog/alu_core.sv
module alu_core import alu_misc_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    input  logic    unsig,
    output word_t   value,
    output logic    overflow
);

    // Shared adder outputs
    word_t sum;
    word_t diff;

    // Signed overflow flags before op selection
    logic add_ov;
    logic sub_ov;

    // Set-less-than compare result
    logic less;

    assign sum  = a + b;
    assign diff = a - b;

    // Add overflows when both operands share a sign the sum does not
    assign add_ov = (a[31] == b[31]) && (sum[31] != a[31]);

    // Subtract overflows when operand signs differ and result sign flips
    assign sub_ov = (a[31] != b[31]) && (diff[31] != a[31]);

    // Signed or unsigned compare
    always_comb begin
        if (unsig) begin
            less = (a < b);
        end else begin
            less = ($signed(a) < $signed(b));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result mux
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            alu_add: value = sum;
            alu_sub: value = diff;
            alu_and: value = a & b;
            alu_or:  value = a | b;
            alu_xor: value = a ^ b;
            alu_nor: value = ~(a | b);
            // 1 or 0 in bit zero
            alu_slt: value = {31'd0, less};
            // Low half of B moves up, low half zero
            alu_lui: value = {b[15:0], 16'h0000};
            default: value = '0;
        endcase
    end

    // Only signed add and subtract can overflow
    always_comb begin
        overflow = 1'b0;
        if (!unsig) begin
            if (op == alu_add) begin
                overflow = add_ov;
            end else if (op == alu_sub) begin
                overflow = sub_ov;
            end
        end
    end

endmodule

//--- verilog/shift_unit.sv
module shift_unit import alu_misc_pkg::*; (
    input  word_t         value,
    input  shift_op_e     op,
    input  shift_amount_t amount,
    output word_t         result
);

    // Bit shifted in on the left, sign only for sra
    logic fill;

    // Stage 0 is the (possibly reversed) input, stage 5 the shifted word
    word_t stage [6];

    assign fill = (op == shift_sra) ? value[31] : 1'b0;

    // Left shift runs through the right shifter with bits reversed
    assign stage[0] = (op == shift_sll) ? {<<{value}} : value;

    // One log stage per amount bit
    for (genvar i = 0; i < 5; i++) begin : g_stage
        localparam int STEP = 1 << i;
        assign stage[i+1] = amount[i] ? {{STEP{fill}}, stage[i][31:STEP]} : stage[i];
    end

    always_comb begin
        case (op)
            shift_sll: result = {<<{stage[5]}};
            shift_srl: result = stage[5];
            shift_sra: result = stage[5];
            default:   result = '0;
        endcase
    end

endmodule

//--- verilog/alu_misc_exec.sv
module alu_misc_exec import alu_misc_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      iss_valid,
    input  issue_op_t iss_op,
    output logic      ex_valid,
    output result_t   ex_result
);

    // Operand B after immediate select
    word_t operand_b;

    // Functional outputs
    word_t alu_value;
    logic  alu_overflow;
    word_t shift_value;

    // Chosen value and effective overflow
    word_t chosen_value;
    logic  overflow;

    assign operand_b = iss_op.sel_imm ? iss_op.imm : iss_op.rb;

    alu_core u_alu (
        .a        (iss_op.ra),
        .b        (operand_b),
        .op       (iss_op.alu_op),
        .unsig    (iss_op.unsig),
        .value    (alu_value),
        .overflow (alu_overflow)
    );

    // Shifter always works on rb
    shift_unit u_shift (
        .value  (iss_op.rb),
        .op     (iss_op.shift_op),
        .amount (iss_op.shift_amount),
        .result (shift_value)
    );

    assign chosen_value = iss_op.sel_shift ? shift_value : alu_value;

    // A shift result never carries the ALU overflow
    assign overflow = alu_overflow && !iss_op.sel_shift;

    ////////////////////////////////////////////////////////////////////////////
    // Stage a0 result register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ex_valid  <= 1'b0;
            ex_result <= '0;
        end else if (iss_valid) begin
            ex_valid            <= 1'b1;
            ex_result.dest      <= iss_op.dest;
            // Overflow drops the write unless the op asks for it anyway
            ex_result.write_reg <= iss_op.write_reg && (!overflow || iss_op.write_on_overflow);
            ex_result.overflow  <= overflow;
            ex_result.value     <= chosen_value;
        end else begin
            // Bubble, empty result
            ex_valid  <= 1'b0;
            ex_result <= '0;
        end
    end

endmodule

//--- verilog/alu_misc_delay.sv
module alu_misc_delay import alu_misc_pkg::*; #(
    parameter int DELAY_STAGES = DEFAULT_DELAY_STAGES
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    in_valid,
    input  result_t in_result,
    output logic    out_valid,
    output result_t out_result
);

    // Stage 0 is nearest the input
    logic    valid_q  [DELAY_STAGES];
    result_t result_q [DELAY_STAGES];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < DELAY_STAGES; i++) begin
                valid_q[i]  <= 1'b0;
                result_q[i] <= '0;
            end
        end else begin
            valid_q[0]  <= in_valid;
            result_q[0] <= in_valid ? in_result : '0;
            // Advance one stage per cycle, bubbles stay zero
            for (int i = 1; i < DELAY_STAGES; i++) begin
                valid_q[i]  <= valid_q[i-1];
                result_q[i] <= valid_q[i-1] ? result_q[i-1] : '0;
            end
        end
    end

    assign out_valid  = valid_q[DELAY_STAGES-1];
    assign out_result = result_q[DELAY_STAGES-1];

endmodule

//--- verilog/alu_misc_result_queue.sv
module alu_misc_result_queue import alu_misc_pkg::*; #(
    parameter int RESULT_DEPTH = DEFAULT_RESULT_DEPTH
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    push,
    input  result_t push_result,
    output logic    wb_valid,
    output result_t wb_result,
    input  logic    wb_grant,
    output logic    iss_credit
);

    localparam int PTR_W = $clog2(RESULT_DEPTH);
    localparam int CNT_W = $clog2(RESULT_DEPTH + 1);

    // Last valid pointer value before wrap
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(RESULT_DEPTH - 1);

    // Storage
    result_t mem [RESULT_DEPTH];

    // Pointers and fill level
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    // Writeback takes the head this cycle
    logic pop;

    assign wb_valid  = (count != '0);
    assign wb_result = mem[rd_ptr];
    assign pop       = wb_valid && wb_grant;

    ////////////////////////////////////////////////////////////////////////////
    // Storage write, no full check since credits bound the fill level
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_result;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers, count and credit return
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            count      <= '0;
            iss_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // Count moves only when one side is active alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            // One credit back the cycle after each pop
            iss_credit <= pop;
        end
    end

endmodule

//--- verilog/alu_misc_unit.sv
module alu_misc_unit import alu_misc_pkg::*; #(
    parameter int DELAY_STAGES = DEFAULT_DELAY_STAGES,
    parameter int RESULT_DEPTH = DEFAULT_RESULT_DEPTH
) (
    input  logic      clock,
    input  logic      reset,
    // Issue side, credit based
    input  logic      iss_valid,
    input  issue_op_t iss_op,
    output logic      iss_credit,
    // Writeback side, arbiter grant
    output logic      wb_valid,
    output result_t   wb_result,
    input  logic      wb_grant
);

    // Stage a0 output
    logic    ex_valid;
    result_t ex_result;

    // Latency-matched result
    logic    dl_valid;
    result_t dl_result;

    alu_misc_exec u_exec (
        .clock     (clock),
        .reset     (reset),
        .iss_valid (iss_valid),
        .iss_op    (iss_op),
        .ex_valid  (ex_valid),
        .ex_result (ex_result)
    );

    alu_misc_delay #(
        .DELAY_STAGES (DELAY_STAGES)
    ) u_delay (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (ex_valid),
        .in_result  (ex_result),
        .out_valid  (dl_valid),
        .out_result (dl_result)
    );

    // Absorbs all back-pressure from writeback
    alu_misc_result_queue #(
        .RESULT_DEPTH (RESULT_DEPTH)
    ) u_queue (
        .clock       (clock),
        .reset       (reset),
        .push        (dl_valid),
        .push_result (dl_result),
        .wb_valid    (wb_valid),
        .wb_result   (wb_result),
        .wb_grant    (wb_grant),
        .iss_credit  (iss_credit)
    );

endmodule

//--- verif/alu_misc_unit_asserts.sv
module alu_misc_unit_asserts import alu_misc_pkg::*; #(
    parameter int DELAY_STAGES = DEFAULT_DELAY_STAGES,
    parameter int RESULT_DEPTH = DEFAULT_RESULT_DEPTH
) (
    input logic                                clock,
    input logic                                reset,
    input logic                                iss_valid,
    input logic                                iss_credit,
    input logic                                wb_valid,
    input result_t                             wb_result,
    input logic                                wb_grant,
    input logic [$clog2(RESULT_DEPTH + 1)-1:0] q_count
);

    timeunit 1ns;
    timeprecision 100ps;

    // One sticky flag per property, the testbench watches any_err
    logic credit_err  = 1'b0;
    logic depth_err   = 1'b0;
    logic stable_err  = 1'b0;
    logic latency_err = 1'b0;
    logic reset_err   = 1'b0;
    logic any_err;

    // Consecutive grant cycles seen before the current edge
    int grant_run = 0;

    assign any_err = credit_err || depth_err || stable_err || latency_err || reset_err;

    always @(posedge clock) begin
        if (!wb_grant) begin
            grant_run <= 0;
        end else if (grant_run < 1000) begin
            grant_run <= grant_run + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Credits and queue fill level
    ////////////////////////////////////////////////////////////////////////////

    // Credit comes back exactly one cycle after each pop
    credit_after_pop: assert property (@(posedge clock) disable iff (!reset)
        iss_credit == $past(wb_valid && wb_grant))
    else begin
        credit_err = 1'b1;
        $error("iss_credit does not follow the writeback pop by one cycle");
    end

    // Credit rule keeps the FIFO within its depth
    queue_in_bounds: assert property (@(posedge clock) disable iff (!reset)
        32'(q_count) <= RESULT_DEPTH)
    else begin
        depth_err = 1'b1;
        $error("result queue count went above its depth");
    end

    // Head held while writeback waits for the arbiter
    result_held: assert property (@(posedge clock) disable iff (!reset)
        (wb_valid && !wb_grant) |=> (wb_valid && $stable(wb_result)))
    else begin
        stable_err = 1'b1;
        $error("wb_result changed while waiting for wb_grant");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Latency with an empty queue and a free write port
    ////////////////////////////////////////////////////////////////////////////

    unit_latency: assert property (@(posedge clock) disable iff (!reset)
        ($past(iss_valid, DELAY_STAGES + 2) && ($past(q_count, DELAY_STAGES + 2) == '0)
            && (grant_run >= DELAY_STAGES + 1)) |-> wb_valid)
    else begin
        latency_err = 1'b1;
        $error("wb_valid missing DELAY_STAGES+2 cycles after issue");
    end

    // Outputs quiet in reset and on the first edge after it
    reset_quiet: assert property (@(posedge clock)
        (!reset || $past(!reset)) |-> (!wb_valid && !iss_credit))
    else begin
        reset_err = 1'b1;
        $error("wb_valid or iss_credit high around reset");
    end

endmodule

bind alu_misc_unit alu_misc_unit_asserts #(
    .DELAY_STAGES (DELAY_STAGES),
    .RESULT_DEPTH (RESULT_DEPTH)
) u_asserts (
    .clock      (clock),
    .reset      (reset),
    .iss_valid  (iss_valid),
    .iss_credit (iss_credit),
    .wb_valid   (wb_valid),
    .wb_result  (wb_result),
    .wb_grant   (wb_grant),
    .q_count    (u_queue.count)
);

//--- verif/alu_misc_unit_tb.sv
module alu_misc_unit_tb import alu_misc_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DELAY_STAGES = DEFAULT_DELAY_STAGES;
    localparam int RESULT_DEPTH = DEFAULT_RESULT_DEPTH;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_OPS      = 400;
    localparam int NUM_DIRECTED = 60;
    // Watchdog budget of 20 cycles per operation plus reset at 10 ns per cycle
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_OPS * 20) * 10;

    // DUT inputs
    logic      clock     = 1'b0;
    logic      reset     = 1'b0;
    logic      iss_valid = 1'b0;
    issue_op_t iss_op    = '0;
    logic      wb_grant  = 1'b0;

    // DUT outputs
    logic    iss_credit;
    logic    wb_valid;
    result_t wb_result;

    // Stimulus state
    int seed    = 60578;
    int credits = RESULT_DEPTH;
    int sent    = 0;
    int cycle   = 0;

    // Scoreboard in issue order
    result_t expected [$];

    alu_misc_unit #(
        .DELAY_STAGES (DELAY_STAGES),
        .RESULT_DEPTH (RESULT_DEPTH)
    ) dut0 (
        .clock      (clock),
        .reset      (reset),
        .iss_valid  (iss_valid),
        .iss_op     (iss_op),
        .iss_credit (iss_credit),
        .wb_valid   (wb_valid),
        .wb_result  (wb_result),
        .wb_grant   (wb_grant)
    );

    always #5 clock = ~clock;

    task automatic stop_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
        assert (got == exp) else begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic result_t expected_result(issue_op_t op);
        result_t     res;
        word_t       b;
        word_t       v;
        logic [32:0] wide;
        logic        ov;
        b    = op.sel_imm ? op.imm : op.rb;
        v    = '0;
        wide = '0;
        ov   = 1'b0;
        if (op.sel_shift) begin
            case (op.shift_op)
                shift_sll: v = op.rb << op.shift_amount;
                shift_srl: v = op.rb >> op.shift_amount;
                shift_sra: v = $signed(op.rb) >>> op.shift_amount;
                default:   v = '0;
            endcase
        end else begin
            case (op.alu_op)
                alu_add: begin
                    v    = op.ra + b;
                    // Top two bits of the sign-extended sum differ on overflow
                    wide = {op.ra[31], op.ra} + {b[31], b};
                    ov   = !op.unsig && (wide[32] != wide[31]);
                end
                alu_sub: begin
                    v    = op.ra - b;
                    wide = {op.ra[31], op.ra} - {b[31], b};
                    ov   = !op.unsig && (wide[32] != wide[31]);
                end
                alu_and: v = op.ra & b;
                alu_or:  v = op.ra | b;
                alu_xor: v = op.ra ^ b;
                alu_nor: v = ~(op.ra | b);
                alu_slt: begin
                    if (op.unsig) begin
                        v = (op.ra < b) ? 32'd1 : 32'd0;
                    end else begin
                        v = ($signed(op.ra) < $signed(b)) ? 32'd1 : 32'd0;
                    end
                end
                default: v = {b[15:0], 16'h0000};
            endcase
        end
        res.dest      = op.dest;
        res.overflow  = ov;
        res.write_reg = op.write_reg && (!ov || op.write_on_overflow);
        res.value     = v;
        return res;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Operation generators
    ////////////////////////////////////////////////////////////////////////////

    // Corner operands for every ALU op and then shifts at fixed distances
    function automatic issue_op_t directed_op(int k);
        issue_op_t op;
        word_t     a;
        word_t     b;
        op = '0;
        case (k % 6)
            0:       begin a = 32'h7fff_ffff; b = 32'h0000_0001; end
            1:       begin a = 32'h8000_0000; b = 32'h0000_0001; end
            2:       begin a = 32'hffff_ffff; b = 32'h0000_0001; end
            3:       begin a = 32'h8000_5678; b = 32'h0000_abcd; end
            4:       begin a = 32'h8000_0000; b = 32'h8000_0000; end
            default: begin a = 32'h0000_0005; b = 32'h0000_0005; end
        endcase
        op.ra        = a;
        op.rb        = b;
        op.imm       = b;
        op.dest      = k[4:0];
        op.write_reg = 1'b1;
        if (k < 40) begin
            op.alu_op            = alu_op_e'(k[2:0]);
            op.unsig             = k[3];
            op.sel_imm           = k[4];
            op.write_on_overflow = k[5];
            op.shift_op          = shift_none;
            // The unselected operand B source holds the inverse
            if (k[4]) begin
                op.rb = ~b;
            end else begin
                op.imm = ~b;
            end
        end else begin
            op.sel_shift = 1'b1;
            op.shift_op  = shift_op_e'(k[1:0]);
            // Sign bit clear for the first half, set for the second
            op.rb = (k < 50) ? 32'h0f0f_a5c3 : 32'h8f0f_a5c3;
            case ((k - 40) % 5)
                0:       op.shift_amount = 5'd0;
                1:       op.shift_amount = 5'd1;
                2:       op.shift_amount = 5'd31;
                3:       op.shift_amount = 5'd16;
                default: op.shift_amount = 5'd5;
            endcase
        end
        return op;
    endfunction

    function automatic issue_op_t random_op();
        issue_op_t   op;
        logic [31:0] r;
        r = $random(seed);
        op.alu_op            = alu_op_e'(r[2:0]);
        op.unsig             = r[3];
        op.shift_op          = shift_op_e'(r[5:4]);
        op.shift_amount      = r[10:6];
        op.sel_shift         = r[11];
        op.sel_imm           = r[12];
        op.dest              = r[17:13];
        op.write_reg         = r[18];
        op.write_on_overflow = r[19];
        op.ra                = $random(seed);
        op.rb                = $random(seed);
        op.imm               = $random(seed);
        // Push some operands to the signed limits so overflow shows up
        if (r[21:20] == 2'b00) begin
            op.ra = {op.ra[31], {31{~op.ra[31]}}};
        end
        return op;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Per-cycle drive, credits, grant pattern and issue
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_cycle();
        logic [31:0] r;
        issue_op_t   op;
        logic        do_issue;
        r = $random(seed);
        cycle++;
        if (iss_credit) begin
            if (credits >= RESULT_DEPTH) begin
                $display("Error: credit returned while no result was outstanding");
                stop_with_failure();
            end
            credits++;
        end
        // Write port free for directed ops and for the drain
        // Long stalls in the middle of the random run
        if (sent < NUM_DIRECTED || sent >= NUM_OPS) begin
            wb_grant = 1'b1;
        end else if (sent >= 200 && sent < 300) begin
            wb_grant = (cycle % 32) >= 24;
        end else begin
            wb_grant = r[7:0] < 8'd154;
        end
        // Directed ops spaced out so each finds the queue empty
        if (sent < NUM_DIRECTED) begin
            do_issue = (cycle % 3) == 0;
        end else if (sent < NUM_OPS) begin
            do_issue = r[11:8] < 4'd11;
        end else begin
            do_issue = 1'b0;
        end
        if (do_issue && credits > 0) begin
            if (sent < NUM_DIRECTED) begin
                op = directed_op(sent);
            end else begin
                op = random_op();
            end
            expected.push_back(expected_result(op));
            credits--;
            sent++;
            iss_op    = op;
            iss_valid = 1'b1;
        end else begin
            iss_op    = '0;
            iss_valid = 1'b0;
        end
    endtask

    // Writeback compare on the falling edge where inputs have settled
    always @(negedge clock) begin
        result_t exp;
        if (reset) begin
            if (dut0.u_asserts.any_err) begin
                $display("Error: a bound assertion on the unit failed");
                stop_with_failure();
            end
            if (wb_valid && wb_grant) begin
                if (expected.size() == 0) begin
                    $display("Error: writeback result with nothing issued");
                    stop_with_failure();
                end else begin
                    exp = expected.pop_front();
                    check_field("wb_result.dest", 32'(wb_result.dest), 32'(exp.dest));
                    check_field("wb_result.write_reg", 32'(wb_result.write_reg),
                                32'(exp.write_reg));
                    check_field("wb_result.overflow", 32'(wb_result.overflow),
                                32'(exp.overflow));
                    check_field("wb_result.value", wb_result.value, exp.value);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the unit did not return all results in time");
        stop_with_failure();
    end

    initial begin
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b1;
        // Done when every op is sent, checked and its credit is back
        while (sent < NUM_OPS || expected.size() != 0 || credits != RESULT_DEPTH) begin
            @(posedge clock);
            #1;
            drive_cycle();
        end
        repeat (4) @(posedge clock);
        #1;
        if (dut0.u_asserts.any_err) begin
            $display("Error: a bound assertion failed near the end of the run");
            stop_with_failure();
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

//--- alu_misc_unit.f
verilog/alu_misc_pkg.sv
verilog/alu_core.sv
verilog/shift_unit.sv
verilog/alu_misc_exec.sv
verilog/alu_misc_delay.sv
verilog/alu_misc_result_queue.sv
verilog/alu_misc_unit.sv
verif/alu_misc_unit_asserts.sv
verif/alu_misc_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = alu_misc_unit_tb
FILELIST  = alu_misc_unit.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+10

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
